// File: list.f
+incdir+logic
logic/oflow_pkg.sv
logic/oflow_sb_if.sv
logic/oflow_min_score_finder.sv
logic/oflow_conflict_resolver.sv
logic/oflow_sb_arbiter.sv
logic/oflow_score_board.sv
logic/oflow_registration_top.sv
verif/oflow_assert.sv
verif/oflow_tb.sv

// File: logic/oflow_conflict_resolver.sv
// conflict resolver
// one pass over all row pairs i < j, reading both through the bus,
// sets the pointer of the worse row when the chosen ids collide
`timescale 1ns/1ps
`include "oflow_macros.svh"

module oflow_conflict_resolver (
	input  logic clk,
	input  logic reset_N,
	input  logic resolve_start,
	output logic resolve_done,
	oflow_sb_if.requester bus
);

	localparam int LAST_ROW = `OFLOW_MAX_ROWS - 1;

	oflow_pkg::resolver_state_e state;
	logic [`OFLOW_ROW_LEN-1:0] row_i, row_j, flip_row;
	logic [`OFLOW_SCORE_LEN-1:0] score_i; // latched chosen entry of row i
	logic [`OFLOW_ID_LEN-1:0] id_i;
	logic ptr_i;
	logic xfer, loser_is_i, need_flip, advance, last_pair, row_end;

	assign xfer = bus.req_valid && bus.req_ready;

	// row j data is live on the bus during its read transfer
	assign loser_is_i = score_i > bus.rd_score; // equal scores -> row j loses
	assign need_flip  = (id_i == bus.rd_id) && (loser_is_i ? !ptr_i : !bus.rd_ptr);
	assign advance    = xfer && ((state == oflow_pkg::RS_READ_J && !need_flip) ||
		state == oflow_pkg::RS_FLIP);
	assign row_end    = int'(row_j) == LAST_ROW;
	assign last_pair  = row_end && (int'(row_i) == LAST_ROW - 1);

	// --------------------------------------------------
	// pair walk FSM
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state    <= oflow_pkg::RS_IDLE;
			row_i    <= '0;
			row_j    <= '0;
			flip_row <= '0;
			score_i  <= '0;
			id_i     <= '0;
			ptr_i    <= 1'b0;
		end else begin
			case (state)
				oflow_pkg::RS_IDLE: if (resolve_start) begin
					row_i <= '0;
					row_j <= 1'b1;
					state <= oflow_pkg::RS_READ_I;
				end
				oflow_pkg::RS_READ_I: if (xfer) begin
					score_i <= bus.rd_score; // fresh, sees earlier flips
					id_i    <= bus.rd_id;
					ptr_i   <= bus.rd_ptr;
					state   <= oflow_pkg::RS_READ_J;
				end
				oflow_pkg::RS_READ_J: if (xfer && need_flip) begin
					flip_row <= loser_is_i ? row_i : row_j;
					state    <= oflow_pkg::RS_FLIP;
				end
				oflow_pkg::RS_DONE: state <= oflow_pkg::RS_IDLE; // single pulse
				default: ;
			endcase
			if (advance) begin
				if (last_pair) begin
					state <= oflow_pkg::RS_DONE;
				end else begin
					state <= oflow_pkg::RS_READ_I;
					if (row_end) begin
						row_i <= row_i + 1'b1; // next i, j restarts at i+1
						row_j <= row_i + 2'd2;
					end else begin
						row_j <= row_j + 1'b1;
					end
				end
			end
		end
	end

	assign resolve_done = (state == oflow_pkg::RS_DONE);

	// bus request per state
	always_comb begin
		bus.req_valid = 1'b0;
		bus.op        = oflow_pkg::SB_READ;
		bus.row       = row_i;
		case (state)
			oflow_pkg::RS_READ_I: bus.req_valid = 1'b1;
			oflow_pkg::RS_READ_J: begin
				bus.req_valid = 1'b1;
				bus.row       = row_j;
			end
			oflow_pkg::RS_FLIP: begin
				bus.req_valid = 1'b1;
				bus.op        = oflow_pkg::SB_SET_PTR;
				bus.row       = flip_row;
			end
			default: ;
		endcase
	end

	// resolver never writes pairs
	assign bus.wr_score0 = '0;
	assign bus.wr_score1 = '0;
	assign bus.wr_id0    = '0;
	assign bus.wr_id1    = '0;

endmodule

// File: logic/oflow_macros.svh
// size defines for the registration stage
// row index, board depth, object id and score widths
`ifndef OFLOW_MACROS_SVH
`define OFLOW_MACROS_SVH

// --------------------------------------------------
// score board geometry
// --------------------------------------------------
`define OFLOW_ROW_LEN   3  // bits of a row index
`define OFLOW_MAX_ROWS  8  // rows in the score board

// --------------------------------------------------
// candidate fields
// --------------------------------------------------
`define OFLOW_ID_LEN    6  // previous-frame object id
`define OFLOW_SCORE_LEN 10 // similarity score, lower is better

`endif

// File: logic/oflow_min_score_finder.sv
// min score finder
// keeps best and second best candidate of the current row,
// writes both pairs to the score board after the last candidate
`timescale 1ns/1ps
`include "oflow_macros.svh"

module oflow_min_score_finder (
	input  logic clk,
	input  logic reset_N,
	input  logic cand_valid,
	output logic cand_ready,
	input  logic [`OFLOW_ROW_LEN-1:0] cand_row,
	input  logic [`OFLOW_ID_LEN-1:0] cand_id,
	input  logic [`OFLOW_SCORE_LEN-1:0] cand_score,
	input  logic cand_last,
	oflow_sb_if.requester bus
);

	oflow_pkg::finder_state_e state;
	logic [`OFLOW_SCORE_LEN-1:0] best_score, sec_score;
	logic [`OFLOW_ID_LEN-1:0] best_id, sec_id;
	logic [`OFLOW_ROW_LEN-1:0] row_q; // held until the write transfers
	logic cand_acc;
	logic wr_xfer;

	assign cand_ready = (state == oflow_pkg::FS_COLLECT);
	assign cand_acc   = cand_valid && cand_ready;
	assign wr_xfer    = bus.req_valid && bus.req_ready;

	// --------------------------------------------------
	// two-entry min tracking, strict compare keeps earlier on tie
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state      <= oflow_pkg::FS_COLLECT;
			best_score <= '1; // max score, nothing seen
			sec_score  <= '1;
			best_id    <= '0;
			sec_id     <= '0;
			row_q      <= '0;
		end else if (cand_acc) begin
			row_q <= cand_row;
			if (cand_score < best_score) begin
				sec_score  <= best_score; // old best slides down
				sec_id     <= best_id;
				best_score <= cand_score;
				best_id    <= cand_id;
			end else if (cand_score < sec_score) begin
				sec_score <= cand_score;
				sec_id    <= cand_id;
			end
			if (cand_last)
				state <= oflow_pkg::FS_WRITE;
		end else if (wr_xfer) begin
			state      <= oflow_pkg::FS_COLLECT;
			best_score <= '1; // fresh pairs for next row
			sec_score  <= '1;
			best_id    <= '0;
			sec_id     <= '0;
		end
	end

	// write request, stable while stalled
	assign bus.req_valid = (state == oflow_pkg::FS_WRITE);
	assign bus.op        = oflow_pkg::SB_WRITE;
	assign bus.row       = row_q;
	assign bus.wr_score0 = best_score;
	assign bus.wr_score1 = sec_score;
	assign bus.wr_id0    = best_id;
	assign bus.wr_id1    = sec_id;

endmodule

// File: logic/oflow_pkg.sv
// shared types of the registration stage
// score board bus opcode, finder and resolver FSM states
package oflow_pkg;

	// score board bus operations
	typedef enum logic [1:0] {
		SB_WRITE   = 2'd0, // store both pairs, clear pointer
		SB_SET_PTR = 2'd1, // move row to its second choice
		SB_READ    = 2'd2  // chosen score, id and pointer
	} sb_op_e;

	// min score finder
	typedef enum logic {
		FS_COLLECT = 1'b0, // taking candidates of a row
		FS_WRITE   = 1'b1  // pushing the two best to the board
	} finder_state_e;

	// conflict resolver
	typedef enum logic [2:0] {
		RS_IDLE, RS_READ_I, RS_READ_J, RS_FLIP, RS_DONE
	} resolver_state_e;

endpackage

// File: logic/oflow_registration_top.sv
// registration stage top
// finder and resolver share the score board through the arbiter
`timescale 1ns/1ps
`include "oflow_macros.svh"

module oflow_registration_top (
	input  logic clk,
	input  logic reset_N,
	input  logic cand_valid,
	output logic cand_ready,
	input  logic [`OFLOW_ROW_LEN-1:0] cand_row,
	input  logic [`OFLOW_ID_LEN-1:0] cand_id,
	input  logic [`OFLOW_SCORE_LEN-1:0] cand_score,
	input  logic cand_last,
	input  logic frame_start,   // clears the board
	input  logic resolve_start,
	output logic resolve_done,
	output logic [`OFLOW_MAX_ROWS*`OFLOW_ID_LEN-1:0] ids_flat,
	input  logic [`OFLOW_ROW_LEN-1:0] buf_row,
	output logic [`OFLOW_ID_LEN-1:0] buf_id
);

	oflow_sb_if fin_bus(); // finder side
	oflow_sb_if res_bus(); // resolver side
	oflow_sb_if sb_bus();  // arbitrated, to the board

	oflow_min_score_finder i_finder (
		.clk(clk), .reset_N(reset_N),
		.cand_valid(cand_valid), .cand_ready(cand_ready), .cand_row(cand_row),
		.cand_id(cand_id), .cand_score(cand_score), .cand_last(cand_last),
		.bus(fin_bus.requester)
	);

	oflow_conflict_resolver i_resolver (
		.clk(clk), .reset_N(reset_N), .resolve_start(resolve_start),
		.resolve_done(resolve_done), .bus(res_bus.requester)
	);

	oflow_sb_arbiter i_arbiter (
		.clk(clk), .reset_N(reset_N),
		.fin(fin_bus.board), .res(res_bus.board), .sb(sb_bus.requester)
	);

	oflow_score_board i_score_board (
		.clk(clk), .reset_N(reset_N), .frame_start(frame_start), .bus(sb_bus.board),
		.ids_flat(ids_flat), .buf_row(buf_row), .buf_id(buf_id)
	);

endmodule

// File: logic/oflow_sb_arbiter.sv
// score board port arbiter
// fixed priority to the finder, grant held while a request stalls
`timescale 1ns/1ps

module oflow_sb_arbiter (
	input logic clk,
	input logic reset_N,
	oflow_sb_if.board fin,
	oflow_sb_if.board res,
	oflow_sb_if.requester sb
);

	logic locked_q; // granted request still waiting
	logic owner_q;  // 1 -> resolver owns the held grant
	logic sel_res;

	// finder wins unless the resolver already holds the port
	assign sel_res = locked_q ? owner_q : (!fin.req_valid && res.req_valid);

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			locked_q <= 1'b0;
			owner_q  <= 1'b0;
		end else begin
			locked_q <= sb.req_valid && !sb.req_ready; // stalled -> keep owner
			owner_q  <= sel_res;
		end
	end

	// --------------------------------------------------
	// request mux
	// --------------------------------------------------
	assign sb.req_valid = sel_res ? res.req_valid : fin.req_valid;
	assign sb.op        = sel_res ? res.op        : fin.op;
	assign sb.row       = sel_res ? res.row       : fin.row;
	assign sb.wr_score0 = sel_res ? res.wr_score0 : fin.wr_score0;
	assign sb.wr_score1 = sel_res ? res.wr_score1 : fin.wr_score1;
	assign sb.wr_id0    = sel_res ? res.wr_id0    : fin.wr_id0;
	assign sb.wr_id1    = sel_res ? res.wr_id1    : fin.wr_id1;

	assign fin.req_ready = !sel_res && sb.req_ready; // loser sees ready low
	assign res.req_ready = sel_res && sb.req_ready;

	// read data fans out, only the owner's transfer uses it
	assign fin.rd_score = sb.rd_score;
	assign fin.rd_id    = sb.rd_id;
	assign fin.rd_ptr   = sb.rd_ptr;
	assign res.rd_score = sb.rd_score;
	assign res.rd_id    = sb.rd_id;
	assign res.rd_ptr   = sb.rd_ptr;

endmodule

// File: logic/oflow_sb_if.sv
// score board access bus
// valid/ready request, write fields, combinational read fields
`timescale 1ns/1ps
`include "oflow_macros.svh"

interface oflow_sb_if;
	logic req_valid;
	logic req_ready;
	oflow_pkg::sb_op_e op;
	logic [`OFLOW_ROW_LEN-1:0] row;
	logic [`OFLOW_SCORE_LEN-1:0] wr_score0; // best
	logic [`OFLOW_SCORE_LEN-1:0] wr_score1; // second best
	logic [`OFLOW_ID_LEN-1:0] wr_id0;
	logic [`OFLOW_ID_LEN-1:0] wr_id1;
	logic [`OFLOW_SCORE_LEN-1:0] rd_score; // chosen entry of row
	logic [`OFLOW_ID_LEN-1:0] rd_id;
	logic rd_ptr;

	modport requester (output req_valid, op, row, wr_score0, wr_score1, wr_id0, wr_id1,
		input req_ready, rd_score, rd_id, rd_ptr);

	modport board (input req_valid, op, row, wr_score0, wr_score1, wr_id0, wr_id1,
		output req_ready, rd_score, rd_id, rd_ptr);

endinterface

// File: logic/oflow_score_board.sv
// score board
// per-row score pair, id pair and pointer, bus port,
// chosen id vector and one-row read port for the frame buffer
`timescale 1ns/1ps
`include "oflow_macros.svh"

module oflow_score_board (
	input  logic clk,
	input  logic reset_N,
	input  logic frame_start,
	oflow_sb_if.board bus,
	output logic [`OFLOW_MAX_ROWS*`OFLOW_ID_LEN-1:0] ids_flat,
	input  logic [`OFLOW_ROW_LEN-1:0] buf_row,
	output logic [`OFLOW_ID_LEN-1:0] buf_id
);

	logic [`OFLOW_SCORE_LEN-1:0] score0_q [`OFLOW_MAX_ROWS];
	logic [`OFLOW_SCORE_LEN-1:0] score1_q [`OFLOW_MAX_ROWS];
	logic [`OFLOW_ID_LEN-1:0] id0_q [`OFLOW_MAX_ROWS];
	logic [`OFLOW_ID_LEN-1:0] id1_q [`OFLOW_MAX_ROWS];
	logic ptr_q [`OFLOW_MAX_ROWS]; // 1 -> second choice
	logic [`OFLOW_SCORE_LEN-1:0] chosen_score [`OFLOW_MAX_ROWS];
	logic [`OFLOW_ID_LEN-1:0] chosen_id [`OFLOW_MAX_ROWS];
	logic xfer;

	assign bus.req_ready = 1'b1; // single cycle access
	assign xfer = bus.req_valid && bus.req_ready;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int r = 0; r < `OFLOW_MAX_ROWS; r++) begin
				score0_q[r] <= '0;
				score1_q[r] <= '0;
				id0_q[r]    <= '0;
				id1_q[r]    <= '0;
				ptr_q[r]    <= 1'b0;
			end
		end else if (frame_start) begin
			for (int r = 0; r < `OFLOW_MAX_ROWS; r++) begin
				score0_q[r] <= '0;
				score1_q[r] <= '0;
				id0_q[r]    <= '0;
				id1_q[r]    <= '0;
				ptr_q[r]    <= 1'b0;
			end
		end else if (xfer && bus.op == oflow_pkg::SB_WRITE) begin
			score0_q[bus.row] <= bus.wr_score0;
			score1_q[bus.row] <= bus.wr_score1;
			id0_q[bus.row]    <= bus.wr_id0;
			id1_q[bus.row]    <= bus.wr_id1;
			ptr_q[bus.row]    <= 1'b0; // new pairs start on best
		end else if (xfer && bus.op == oflow_pkg::SB_SET_PTR) begin
			ptr_q[bus.row] <= 1'b1;
		end
	end

	// chosen entry per row
	for (genvar r = 0; r < `OFLOW_MAX_ROWS; r++) begin : g_row
		assign chosen_score[r] = ptr_q[r] ? score1_q[r] : score0_q[r];
		assign chosen_id[r]    = ptr_q[r] ? id1_q[r] : id0_q[r];
		assign ids_flat[r*`OFLOW_ID_LEN +: `OFLOW_ID_LEN] = chosen_id[r]; // row 0 low
	end

	// combinational reads
	assign bus.rd_score = chosen_score[bus.row];
	assign bus.rd_id    = chosen_id[bus.row];
	assign bus.rd_ptr   = ptr_q[bus.row];
	assign buf_id       = chosen_id[buf_row];

endmodule

// File: run.sh
#!/bin/sh
# build and run the registration stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module oflow_tb -o oflow_sim

# error limit raised so assertion failures reach the closing summary
out=$(./obj_dir/oflow_sim +verilator+error+limit+1000 || true)
echo "$out"

if echo "$out" | grep -q "TEST PASS"; then
	exit 0
fi
exit 1

// File: verif/oflow_assert.sv
// concurrent checks bound into the registration top
// stalled requests hold, no bus access during clear, done is one cycle
`timescale 1ns/1ps
`include "oflow_macros.svh"

module oflow_assert (
	input logic clk,
	input logic reset_N,
	input logic frame_start,
	input logic resolve_done,
	input logic res_valid,
	input logic res_ready,
	input logic [1:0] res_op,
	input logic [`OFLOW_ROW_LEN-1:0] res_row,
	input logic sb_valid,
	input logic sb_ready
);

	int fail_cnt = 0; // picked up by the testbench summary

	// --------------------------------------------------
	// request stability while stalled
	// --------------------------------------------------
	// resolver loses the port whenever the finder is writing
	a_res_hold: assert property (@(posedge clk) disable iff (!reset_N)
		res_valid && !res_ready |=> res_valid && $stable(res_op) && $stable(res_row))
		else begin
			$error("resolver request changed while stalled");
			fail_cnt++;
		end

	// board clear and a bus transfer never share a cycle
	a_clear_idle: assert property (@(posedge clk) disable iff (!reset_N)
		frame_start |-> !(sb_valid && sb_ready))
		else begin
			$error("bus transfer in the frame_start cycle");
			fail_cnt++;
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		resolve_done |=> !resolve_done)
		else begin
			$error("resolve_done high for two cycles");
			fail_cnt++;
		end

endmodule

bind oflow_registration_top oflow_assert i_oflow_assert (
	.clk(clk), .reset_N(reset_N), .frame_start(frame_start), .resolve_done(resolve_done),
	.res_valid(res_bus.req_valid), .res_ready(res_bus.req_ready), .res_op(res_bus.op),
	.res_row(res_bus.row), .sb_valid(sb_bus.req_valid), .sb_ready(sb_bus.req_ready)
);

// File: verif/oflow_tb.sv
// testbench of the registration stage
// directed and random frames, reference model, compare process,
// cycle limit and closing summary
`timescale 1ns/1ps
`include "oflow_macros.svh"

module oflow_tb;

	localparam int ROWS    = `OFLOW_MAX_ROWS;
	localparam int IDW     = `OFLOW_ID_LEN;
	localparam int SCW     = `OFLOW_SCORE_LEN;
	localparam int FRAMES  = 8; // frame 0 and 1 directed, rest random
	localparam int MAX_SC  = (1 << SCW) - 1;
	localparam int RES_CYC = ROWS*(ROWS-1)/2*3 + 2*ROWS + 4; // pair scan plus buf sweep
	localparam int LIMIT   = FRAMES*ROWS*6*4 + FRAMES*RES_CYC + 500;
	// conflict frame, best entry of each row
	localparam int CF_ID [ROWS] = '{5, 5, 9, 9, 41, 20, 21, 22};
	localparam int CF_SC [ROWS] = '{10, 12, 7, 7, 3, 30, 31, 32};

	logic clk = 1'b0;
	logic reset_N;
	logic cand_valid, cand_ready, cand_last;
	logic [`OFLOW_ROW_LEN-1:0] cand_row, buf_row;
	logic [IDW-1:0] cand_id, buf_id;
	logic [SCW-1:0] cand_score;
	logic frame_start, resolve_start, resolve_done;
	logic [ROWS*IDW-1:0] ids_flat;

	int c_id [ROWS][6]; // candidates of the current frame
	int c_sc [ROWS][6];
	int c_cnt [ROWS];
	int err_cnt = 0;
	int checked = 0; // frames compared so far
	int cycles  = 0;
	integer seed = 32'h1c25811b;

	oflow_registration_top i_dut (
		.clk(clk), .reset_N(reset_N),
		.cand_valid(cand_valid), .cand_ready(cand_ready), .cand_row(cand_row),
		.cand_id(cand_id), .cand_score(cand_score), .cand_last(cand_last),
		.frame_start(frame_start), .resolve_start(resolve_start),
		.resolve_done(resolve_done), .ids_flat(ids_flat),
		.buf_row(buf_row), .buf_id(buf_id)
	);

	always #2 clk = ~clk; // 4 ns period

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic logic [ROWS*IDW-1:0] oflow_ref();
		int b_sc [ROWS];
		int b_id [ROWS];
		int s_sc [ROWS];
		int s_id [ROWS];
		bit ptr [ROWS];
		int sc_i, sc_j, id_i, id_j;
		logic [ROWS*IDW-1:0] v;
		for (int r = 0; r < ROWS; r++) begin
			b_sc[r] = MAX_SC;
			s_sc[r] = MAX_SC;
			b_id[r] = 0;
			s_id[r] = 0;
			ptr[r]  = 1'b0;
			for (int k = 0; k < c_cnt[r]; k++) begin
				if (c_sc[r][k] < b_sc[r]) begin // strict, earlier wins a tie
					s_sc[r] = b_sc[r];
					s_id[r] = b_id[r];
					b_sc[r] = c_sc[r][k];
					b_id[r] = c_id[r][k];
				end else if (c_sc[r][k] < s_sc[r]) begin
					s_sc[r] = c_sc[r][k];
					s_id[r] = c_id[r][k];
				end
			end
		end
		// one pass, i then j ascending, each pair sees earlier flips
		for (int i = 0; i < ROWS - 1; i++) begin
			for (int j = i + 1; j < ROWS; j++) begin
				sc_i = ptr[i] ? s_sc[i] : b_sc[i];
				id_i = ptr[i] ? s_id[i] : b_id[i];
				sc_j = ptr[j] ? s_sc[j] : b_sc[j];
				id_j = ptr[j] ? s_id[j] : b_id[j];
				if (id_i == id_j) begin
					if (sc_i > sc_j)
						ptr[i] = 1'b1; // already set stays set
					else
						ptr[j] = 1'b1; // equal score, row j loses
				end
			end
		end
		for (int r = 0; r < ROWS; r++)
			v[r*IDW +: IDW] = IDW'(ptr[r] ? s_id[r] : b_id[r]);
		return v;
	endfunction

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	task automatic build_frame(input int f);
		for (int r = 0; r < ROWS; r++) begin
			if (f == 0) begin
				c_cnt[r] = 4; // distinct ids, tie on the best score
				for (int k = 0; k < 4; k++)
					c_id[r][k] = r*7 + k;
				c_sc[r][0] = 40 + r;
				c_sc[r][1] = 20 + r;
				c_sc[r][2] = 20 + r;
				c_sc[r][3] = 30 + r;
			end else if (f == 1) begin
				c_cnt[r] = 2; // rows 0/1 and 2/3 collide, row 4 hits row 1's second
				c_id[r][0] = CF_ID[r];
				c_sc[r][0] = CF_SC[r];
				c_id[r][1] = 40 + r;
				c_sc[r][1] = CF_SC[r] + 5;
			end else begin
				c_cnt[r] = 1 + {$random(seed)} % 6;
				for (int k = 0; k < c_cnt[r]; k++) begin
					c_id[r][k] = {$random(seed)} % 6; // narrow id range
					c_sc[r][k] = {$random(seed)} % 16;
				end
			end
		end
	endtask

	// entered and left 1 ns after a rising edge
	task automatic send_cand(input int r, input int k, input bit last, input bit start_res);
		int gap;
		bit taken;
		gap = {$random(seed)} % 3;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		// resolve pulse lands on the edge that takes this candidate
		while (start_res && !cand_ready) begin
			@(posedge clk);
			#1;
		end
		cand_valid    = 1'b1;
		cand_row      = r[`OFLOW_ROW_LEN-1:0];
		cand_id       = c_id[r][k][IDW-1:0];
		cand_score    = c_sc[r][k][SCW-1:0];
		cand_last     = last;
		resolve_start = start_res;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = cand_ready; // stable mid cycle
			@(posedge clk);
			#1;
		end
		cand_valid    = 1'b0;
		resolve_start = 1'b0;
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin : stimulus
		int a_cnt;
		reset_N       = 1'b0;
		cand_valid    = 1'b0;
		cand_row      = '0;
		cand_id       = '0;
		cand_score    = '0;
		cand_last     = 1'b0;
		frame_start   = 1'b0;
		resolve_start = 1'b0;
		buf_row       = '0;
		repeat (3) @(posedge clk);
		#1;
		reset_N = 1'b1;
		@(negedge clk);
		check("cand_ready", cand_ready, 1'b1); // finder collecting after reset
		check("resolve_done", resolve_done, 1'b0);
		@(posedge clk);
		#1;
		for (int f = 0; f < FRAMES; f++) begin
			build_frame(f);
			frame_start = 1'b1;
			@(posedge clk);
			#1;
			frame_start = 1'b0;
			@(negedge clk);
			check("ids_flat", ids_flat, '0); // board cleared
			@(posedge clk);
			#1;
			// last row write and first resolver read contend for the board
			for (int r = 0; r < ROWS; r++)
				for (int k = 0; k < c_cnt[r]; k++)
					send_cand(r, k, k == c_cnt[r] - 1, r == ROWS - 1 && k == c_cnt[r] - 1);
			wait (checked == f + 1);
			@(posedge clk);
			#1;
		end
		a_cnt = i_dut.i_oflow_assert.fail_cnt;
		$display("errors: %0d value checks, %0d assertions", err_cnt, a_cnt);
		if (err_cnt == 0 && a_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// --------------------------------------------------
	// compare after each resolve pass
	// --------------------------------------------------
	initial begin : compare
		logic [ROWS*IDW-1:0] exp_v;
		forever begin
			@(negedge clk);
			if (resolve_done) begin
				exp_v = oflow_ref();
				for (int r = 0; r < ROWS; r++)
					check($sformatf("ids_flat row %0d", r), ids_flat[r*IDW +: IDW],
						exp_v[r*IDW +: IDW]);
				// frame buffer port, one row per cycle
				for (int r = 0; r < ROWS; r++) begin
					@(posedge clk);
					#1;
					buf_row = r[`OFLOW_ROW_LEN-1:0];
					@(negedge clk);
					check($sformatf("buf_id row %0d", r), buf_id, exp_v[r*IDW +: IDW]);
				end
				checked++;
			end
		end
	end

endmodule
